//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := core_tb
FLIST    := list.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

//--- list.f
+incdir+logic
logic/core_pkg.sv
logic/core_bus_if.sv
logic/core_ifu.sv
logic/core_idu.sv
logic/core_exu.sv
logic/core_lsu.sv
logic/core_xbar.sv
logic/core_clint.sv
logic/core_top.sv
test/core_assert.sv
test/core_tb.sv

//--- logic/core_bus_if.sv
interface core_bus_if;
	// read address and data
	logic [31:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	// write address, data and response
	logic [31:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;

	modport master (
		output araddr, arvalid, rready, awaddr, awvalid, wdata, wvalid, bready,
		input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);

	modport slave (
		input  araddr, arvalid, rready, awaddr, awvalid, wdata, wvalid, bready,
		output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);
endinterface

//--- logic/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// first fetch address after reset
`define CORE_RESET_PC   32'h0000_0000

// mtime window, 8 bytes starting here
`define CORE_CLINT_BASE 32'h0200_0000

// RV32E register count
`define CORE_NREGS      16

`endif

//--- logic/core_clint.sv
module core_clint (
	input  logic      clock,
	input  logic      arst_n,
	core_bus_if.slave bus
);
	logic [63:0] mtime;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			mtime <= 64'd0;
		end else begin
			mtime <= mtime + 64'd1;
		end
	end

	// response one cycle after the address is taken
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			bus.rvalid <= 1'b0;
		end else if (bus.arvalid && bus.arready) begin
			bus.rvalid <= 1'b1;
		end else if (bus.rready) begin
			bus.rvalid <= 1'b0;
		end
	end

	// offset 4 selects the high word
	always_ff @(posedge clock) begin
		if (bus.arvalid && bus.arready)
			bus.rdata <= bus.araddr[2] ? mtime[63:32] : mtime[31:0];
	end

	assign bus.arready = !bus.rvalid;
	assign bus.rresp   = 2'b00;
	assign bus.awready = 1'b0;
	assign bus.wready  = 1'b0;
	assign bus.bvalid  = 1'b0;
	assign bus.bresp   = 2'b00;
endmodule

//--- logic/core_exu.sv
module core_exu import core_pkg::*; (
	input  logic        clock,
	input  logic        arst_n,
	input  opcode_e     op,
	input  logic [3:0]  rd,
	input  logic [31:0] src1,
	input  logic [31:0] src2,
	input  logic [31:0] imm,
	input  logic [31:0] pc,
	input  logic        exu_valid,
	output logic        exu_ready,
	output logic [31:0] result,
	output logic [31:0] store_data,
	output logic [31:0] next_pc,
	output logic        mem_ren,
	output logic        mem_wen,
	output logic        reg_wen,
	output logic [3:0]  rd_out,
	output logic        lsu_valid,
	input  logic        lsu_ready
);
	alu_op_e     alu_op;
	logic [31:0] alu_a;
	logic [31:0] alu_b;
	logic [31:0] alu_res;
	logic        ren;
	logic        wen;
	logic        reg_en;
	logic        taken;
	logic        accept;

	assign exu_ready = !lsu_valid;
	assign accept    = exu_valid && exu_ready;

	// operands default to src1 + imm
	always_comb begin
		alu_op = ALU_ADD;
		alu_a  = src1;
		alu_b  = imm;
		ren    = 1'b0;
		wen    = 1'b0;
		reg_en = 1'b0;
		case (op)
			OP_ADDI: reg_en = 1'b1;
			OP_ADD: begin
				alu_b  = src2;
				reg_en = 1'b1;
			end
			OP_SUB: begin
				alu_op = ALU_SUB;
				alu_b  = src2;
				reg_en = 1'b1;
			end
			OP_LUI: begin
				alu_op = ALU_PASS;
				reg_en = 1'b1;
			end
			OP_LW: begin
				ren    = 1'b1;
				reg_en = 1'b1;
			end
			OP_SW: wen = 1'b1;
			OP_BEQ: begin
				alu_op = ALU_SUB;
				alu_b  = src2;
			end
			// link address
			OP_JAL: begin
				alu_a  = pc;
				alu_b  = 32'd4;
				reg_en = 1'b1;
			end
			default: alu_op = ALU_PASS;
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_SUB:  alu_res = alu_a - alu_b;
			ALU_PASS: alu_res = alu_b;
			default:  alu_res = alu_a + alu_b;
		endcase
	end

	// beq compares through the subtractor
	assign taken = (op == OP_JAL) || (op == OP_BEQ && alu_res == 32'd0);

	always_ff @(posedge clock) begin
		if (accept) begin
			result     <= alu_res;
			store_data <= src2;
			next_pc    <= taken ? pc + imm : pc + 32'd4;
			mem_ren    <= ren;
			mem_wen    <= wen;
			reg_wen    <= reg_en;
			rd_out     <= rd;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			lsu_valid <= 1'b0;
		end else if (accept) begin
			lsu_valid <= 1'b1;
		end else if (lsu_ready) begin
			lsu_valid <= 1'b0;
		end
	end
endmodule

//--- logic/core_idu.sv
`include "core_cfg.svh"

module core_idu import core_pkg::*; (
	input  logic        clock,
	input  logic        arst_n,
	input  logic [31:0] inst,
	input  logic [31:0] pc,
	input  logic        idu_valid,
	output logic        idu_ready,
	output opcode_e     op,
	output logic [3:0]  rd,
	output logic [31:0] src1,
	output logic [31:0] src2,
	output logic [31:0] imm,
	output logic [31:0] pc_out,
	output logic        exu_valid,
	input  logic        exu_ready,
	input  logic        wb_valid,
	input  logic [3:0]  wb_rd,
	input  logic        wb_wen,
	input  logic [31:0] wb_data
);
	logic [31:0] regs [`CORE_NREGS];
	opcode_e     dec_op;
	logic [31:0] dec_imm;
	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [3:0]  rs1;
	logic [3:0]  rs2;
	logic        accept;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rs1    = inst[18:15];
	assign rs2    = inst[23:20];

	assign idu_ready = !exu_valid;
	assign accept    = idu_valid && idu_ready;

	// ============================================================
	// decode
	// ============================================================
	always_comb begin
		dec_op  = OP_ILLEGAL;
		dec_imm = {{20{inst[31]}}, inst[31:20]};
		case (opcode)
			7'b0010011: begin
				if (funct3 == 3'b000)
					dec_op = OP_ADDI;
			end
			7'b0110011: begin
				if (funct3 == 3'b000 && funct7 == 7'b0000000)
					dec_op = OP_ADD;
				else if (funct3 == 3'b000 && funct7 == 7'b0100000)
					dec_op = OP_SUB;
			end
			7'b0110111: begin
				dec_op  = OP_LUI;
				dec_imm = {inst[31:12], 12'b0};
			end
			7'b0000011: begin
				if (funct3 == 3'b010)
					dec_op = OP_LW;
			end
			7'b0100011: begin
				if (funct3 == 3'b010)
					dec_op = OP_SW;
				dec_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			end
			7'b1100011: begin
				if (funct3 == 3'b000)
					dec_op = OP_BEQ;
				dec_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			7'b1101111: begin
				dec_op  = OP_JAL;
				dec_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			default: dec_op = OP_ILLEGAL;
		endcase
	end

	// ============================================================
	// register file, x0 never written
	// ============================================================
	always_ff @(posedge clock) begin
		if (wb_valid && wb_wen && wb_rd != 4'd0)
			regs[wb_rd] <= wb_data;
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			op     <= dec_op;
			rd     <= inst[10:7];
			src1   <= (rs1 == 4'd0) ? 32'd0 : regs[rs1];
			src2   <= (rs2 == 4'd0) ? 32'd0 : regs[rs2];
			imm    <= dec_imm;
			pc_out <= pc;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			exu_valid <= 1'b0;
		end else if (accept) begin
			exu_valid <= 1'b1;
		end else if (exu_ready) begin
			exu_valid <= 1'b0;
		end
	end
endmodule

//--- logic/core_ifu.sv
`include "core_cfg.svh"

module core_ifu import core_pkg::*; (
	input  logic        clock,
	input  logic        arst_n,
	core_bus_if.master  bus,
	input  logic        wb_valid,
	input  logic [31:0] next_pc,
	output logic [31:0] inst,
	output logic [31:0] pc,
	output logic        idu_valid,
	input  logic        idu_ready
);
	ifu_state_e state;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pc <= `CORE_RESET_PC;
		end else if (wb_valid) begin
			pc <= next_pc;
		end
	end

	// one fetch per retired instruction
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= IFU_BOOT;
		end else begin
			case (state)
				IFU_BOOT: state <= IFU_ADDR;
				IFU_ADDR: begin
					if (bus.arready)
						state <= IFU_DATA;
				end
				IFU_DATA: begin
					if (bus.rvalid)
						state <= IFU_ISSUE;
				end
				IFU_ISSUE: begin
					if (idu_ready)
						state <= IFU_WAIT;
				end
				IFU_WAIT: begin
					if (wb_valid)
						state <= IFU_ADDR;
				end
				default: state <= IFU_BOOT;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (bus.rvalid && bus.rready)
			inst <= bus.rdata;
	end

	assign bus.araddr  = pc;
	assign bus.arvalid = (state == IFU_ADDR);
	assign bus.rready  = (state == IFU_DATA);
	assign idu_valid   = (state == IFU_ISSUE);

	// fetch never writes
	assign bus.awaddr  = '0;
	assign bus.awvalid = 1'b0;
	assign bus.wdata   = '0;
	assign bus.wvalid  = 1'b0;
	assign bus.bready  = 1'b0;
endmodule

//--- logic/core_lsu.sv
module core_lsu import core_pkg::*; (
	input  logic        clock,
	input  logic        arst_n,
	core_bus_if.master  bus,
	input  logic [31:0] result,
	input  logic [31:0] store_data,
	input  logic [31:0] next_pc,
	input  logic        mem_ren,
	input  logic        mem_wen,
	input  logic        reg_wen,
	input  logic [3:0]  rd,
	input  logic        lsu_valid,
	output logic        lsu_ready,
	output logic        wb_valid,
	output logic [3:0]  wb_rd,
	output logic        wb_wen,
	output logic [31:0] wb_data,
	output logic [31:0] pc_out
);
	lsu_state_e  state;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic        is_write;
	logic        aw_done;
	logic        w_done;
	logic        aw_fire;
	logic        w_fire;
	logic        accept;

	assign lsu_ready = (state == LSU_IDLE) && !wb_valid;
	assign accept    = lsu_valid && lsu_ready;

	assign bus.araddr  = addr;
	assign bus.arvalid = (state == LSU_ADDR) && !is_write;
	assign bus.rready  = (state == LSU_DATA);
	assign bus.awaddr  = addr;
	assign bus.awvalid = (state == LSU_ADDR) && is_write && !aw_done;
	assign bus.wdata   = wdata;
	assign bus.wvalid  = (state == LSU_ADDR) && is_write && !w_done;
	assign bus.bready  = (state == LSU_RESP);

	assign aw_fire = bus.awvalid && bus.awready;
	assign w_fire  = bus.wvalid && bus.wready;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state    <= LSU_IDLE;
			aw_done  <= 1'b0;
			w_done   <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= 1'b0;
			case (state)
				LSU_IDLE: begin
					if (accept && (mem_ren || mem_wen))
						state <= LSU_ADDR;
					else if (accept)
						wb_valid <= 1'b1;
				end
				LSU_ADDR: begin
					if (!is_write && bus.arready) begin
						state <= LSU_DATA;
					end else if (is_write) begin
						// aw and w may complete in either order
						if ((aw_done || aw_fire) && (w_done || w_fire)) begin
							state   <= LSU_RESP;
							aw_done <= 1'b0;
							w_done  <= 1'b0;
						end else begin
							aw_done <= aw_done || aw_fire;
							w_done  <= w_done || w_fire;
						end
					end
				end
				LSU_DATA: begin
					if (bus.rvalid) begin
						state    <= LSU_IDLE;
						wb_valid <= 1'b1;
					end
				end
				LSU_RESP: begin
					if (bus.bvalid) begin
						state    <= LSU_IDLE;
						wb_valid <= 1'b1;
					end
				end
				default: state <= LSU_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			addr     <= result;
			wdata    <= store_data;
			is_write <= mem_wen;
			wb_rd    <= rd;
			wb_wen   <= reg_wen;
			pc_out   <= next_pc;
			wb_data  <= result;
		end else if (bus.rvalid && bus.rready) begin
			wb_data  <= bus.rdata;
		end
	end
endmodule

//--- logic/core_pkg.sv
package core_pkg;

	// decoded instruction class
	typedef enum logic [3:0] {
		OP_ADDI,
		OP_ADD,
		OP_SUB,
		OP_LUI,
		OP_LW,
		OP_SW,
		OP_BEQ,
		OP_JAL,
		OP_ILLEGAL
	} opcode_e;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_PASS
	} alu_op_e;

	typedef enum logic [2:0] {
		IFU_BOOT,
		IFU_ADDR,
		IFU_DATA,
		IFU_ISSUE,
		IFU_WAIT
	} ifu_state_e;

	typedef enum logic [1:0] {
		LSU_IDLE,
		LSU_ADDR,
		LSU_DATA,
		LSU_RESP
	} lsu_state_e;

	typedef enum logic [2:0] {
		XBAR_IDLE,
		XBAR_IFU_RD,
		XBAR_LSU_RD,
		XBAR_LSU_WR,
		XBAR_CLINT_RD
	} xbar_state_e;

endpackage

//--- logic/core_top.sv
module core_top import core_pkg::*; (
	input  logic        clock,
	input  logic        arst_n,

	input  logic        io_master_awready,
	output logic        io_master_awvalid,
	output logic [31:0] io_master_awaddr,
	input  logic        io_master_wready,
	output logic        io_master_wvalid,
	output logic [31:0] io_master_wdata,
	output logic        io_master_bready,
	input  logic        io_master_bvalid,
	input  logic [1:0]  io_master_bresp,
	input  logic        io_master_arready,
	output logic        io_master_arvalid,
	output logic [31:0] io_master_araddr,
	output logic        io_master_rready,
	input  logic        io_master_rvalid,
	input  logic [1:0]  io_master_rresp,
	input  logic [31:0] io_master_rdata
);
	// fetch to decode
	logic [31:0] inst;
	logic [31:0] ifu_pc;
	logic        idu_valid;
	logic        idu_ready;
	// decode to execute
	opcode_e     op;
	logic [3:0]  idu_rd;
	logic [31:0] src1;
	logic [31:0] src2;
	logic [31:0] imm;
	logic [31:0] idu_pc;
	logic        exu_valid;
	logic        exu_ready;
	// execute to load/store
	logic [31:0] exu_result;
	logic [31:0] store_data;
	logic [31:0] exu_next_pc;
	logic        mem_ren;
	logic        mem_wen;
	logic        exu_reg_wen;
	logic [3:0]  exu_rd;
	logic        lsu_valid;
	logic        lsu_ready;
	// write-back and retire
	logic        wb_valid;
	logic [3:0]  wb_rd;
	logic        wb_wen;
	logic [31:0] wb_data;
	logic [31:0] wb_pc;

	core_bus_if ifu_bus ();
	core_bus_if lsu_bus ();
	core_bus_if clint_bus ();

	// ============================================================
	// stages
	// ============================================================
	core_ifu u_ifu (
		.clock(clock),
		.arst_n(arst_n),
		.bus(ifu_bus.master),
		.wb_valid(wb_valid),
		.next_pc(wb_pc),
		.inst(inst),
		.pc(ifu_pc),
		.idu_valid(idu_valid),
		.idu_ready(idu_ready)
	);

	core_idu u_idu (
		.clock(clock),
		.arst_n(arst_n),
		.inst(inst),
		.pc(ifu_pc),
		.idu_valid(idu_valid),
		.idu_ready(idu_ready),
		.op(op),
		.rd(idu_rd),
		.src1(src1),
		.src2(src2),
		.imm(imm),
		.pc_out(idu_pc),
		.exu_valid(exu_valid),
		.exu_ready(exu_ready),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_wen(wb_wen),
		.wb_data(wb_data)
	);

	core_exu u_exu (
		.clock(clock),
		.arst_n(arst_n),
		.op(op),
		.rd(idu_rd),
		.src1(src1),
		.src2(src2),
		.imm(imm),
		.pc(idu_pc),
		.exu_valid(exu_valid),
		.exu_ready(exu_ready),
		.result(exu_result),
		.store_data(store_data),
		.next_pc(exu_next_pc),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.reg_wen(exu_reg_wen),
		.rd_out(exu_rd),
		.lsu_valid(lsu_valid),
		.lsu_ready(lsu_ready)
	);

	core_lsu u_lsu (
		.clock(clock),
		.arst_n(arst_n),
		.bus(lsu_bus.master),
		.result(exu_result),
		.store_data(store_data),
		.next_pc(exu_next_pc),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.reg_wen(exu_reg_wen),
		.rd(exu_rd),
		.lsu_valid(lsu_valid),
		.lsu_ready(lsu_ready),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_wen(wb_wen),
		.wb_data(wb_data),
		.pc_out(wb_pc)
	);

	// ============================================================
	// memory side
	// ============================================================
	core_xbar u_xbar (
		.clock(clock),
		.arst_n(arst_n),
		.ifu_bus(ifu_bus.slave),
		.lsu_bus(lsu_bus.slave),
		.clint_bus(clint_bus.master),
		.io_master_awready(io_master_awready),
		.io_master_awvalid(io_master_awvalid),
		.io_master_awaddr(io_master_awaddr),
		.io_master_wready(io_master_wready),
		.io_master_wvalid(io_master_wvalid),
		.io_master_wdata(io_master_wdata),
		.io_master_bready(io_master_bready),
		.io_master_bvalid(io_master_bvalid),
		.io_master_bresp(io_master_bresp),
		.io_master_arready(io_master_arready),
		.io_master_arvalid(io_master_arvalid),
		.io_master_araddr(io_master_araddr),
		.io_master_rready(io_master_rready),
		.io_master_rvalid(io_master_rvalid),
		.io_master_rresp(io_master_rresp),
		.io_master_rdata(io_master_rdata)
	);

	core_clint u_clint (
		.clock(clock),
		.arst_n(arst_n),
		.bus(clint_bus.slave)
	);
endmodule

//--- logic/core_xbar.sv
`include "core_cfg.svh"

module core_xbar import core_pkg::*; (
	input  logic        clock,
	input  logic        arst_n,
	core_bus_if.slave   ifu_bus,
	core_bus_if.slave   lsu_bus,
	core_bus_if.master  clint_bus,

	input  logic        io_master_awready,
	output logic        io_master_awvalid,
	output logic [31:0] io_master_awaddr,
	input  logic        io_master_wready,
	output logic        io_master_wvalid,
	output logic [31:0] io_master_wdata,
	output logic        io_master_bready,
	input  logic        io_master_bvalid,
	input  logic [1:0]  io_master_bresp,
	input  logic        io_master_arready,
	output logic        io_master_arvalid,
	output logic [31:0] io_master_araddr,
	output logic        io_master_rready,
	input  logic        io_master_rvalid,
	input  logic [1:0]  io_master_rresp,
	input  logic [31:0] io_master_rdata
);
	localparam logic [31:0] CLINT_BASE = `CORE_CLINT_BASE;

	xbar_state_e state;
	logic        lsu_to_clint;

	assign lsu_to_clint = (lsu_bus.araddr[31:3] == CLINT_BASE[31:3]);

	// ============================================================
	// grant, load/store ahead of fetch
	// ============================================================
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= XBAR_IDLE;
		end else begin
			case (state)
				XBAR_IDLE: begin
					if (lsu_bus.arvalid)
						state <= lsu_to_clint ? XBAR_CLINT_RD : XBAR_LSU_RD;
					else if (lsu_bus.awvalid || lsu_bus.wvalid)
						state <= XBAR_LSU_WR;
					else if (ifu_bus.arvalid)
						state <= XBAR_IFU_RD;
				end
				XBAR_IFU_RD: begin
					if (ifu_bus.rvalid && ifu_bus.rready)
						state <= XBAR_IDLE;
				end
				XBAR_LSU_RD, XBAR_CLINT_RD: begin
					if (lsu_bus.rvalid && lsu_bus.rready)
						state <= XBAR_IDLE;
				end
				XBAR_LSU_WR: begin
					if (lsu_bus.bvalid && lsu_bus.bready)
						state <= XBAR_IDLE;
				end
				default: state <= XBAR_IDLE;
			endcase
		end
	end

	// ============================================================
	// handshake routing
	// ============================================================
	always_comb begin
		io_master_arvalid = 1'b0;
		io_master_rready  = 1'b0;
		io_master_awvalid = 1'b0;
		io_master_wvalid  = 1'b0;
		io_master_bready  = 1'b0;
		clint_bus.arvalid = 1'b0;
		clint_bus.rready  = 1'b0;
		ifu_bus.arready   = 1'b0;
		ifu_bus.rvalid    = 1'b0;
		lsu_bus.arready   = 1'b0;
		lsu_bus.rvalid    = 1'b0;
		lsu_bus.awready   = 1'b0;
		lsu_bus.wready    = 1'b0;
		lsu_bus.bvalid    = 1'b0;
		case (state)
			XBAR_IFU_RD: begin
				io_master_arvalid = ifu_bus.arvalid;
				io_master_rready  = ifu_bus.rready;
				ifu_bus.arready   = io_master_arready;
				ifu_bus.rvalid    = io_master_rvalid;
			end
			XBAR_LSU_RD: begin
				io_master_arvalid = lsu_bus.arvalid;
				io_master_rready  = lsu_bus.rready;
				lsu_bus.arready   = io_master_arready;
				lsu_bus.rvalid    = io_master_rvalid;
			end
			XBAR_LSU_WR: begin
				io_master_awvalid = lsu_bus.awvalid;
				io_master_wvalid  = lsu_bus.wvalid;
				io_master_bready  = lsu_bus.bready;
				lsu_bus.awready   = io_master_awready;
				lsu_bus.wready    = io_master_wready;
				lsu_bus.bvalid    = io_master_bvalid;
			end
			XBAR_CLINT_RD: begin
				clint_bus.arvalid = lsu_bus.arvalid;
				clint_bus.rready  = lsu_bus.rready;
				lsu_bus.arready   = clint_bus.arready;
				lsu_bus.rvalid    = clint_bus.rvalid;
			end
			default: begin
			end
		endcase
	end

	assign io_master_araddr = (state == XBAR_IFU_RD) ? ifu_bus.araddr : lsu_bus.araddr;
	assign io_master_awaddr = lsu_bus.awaddr;
	assign io_master_wdata  = lsu_bus.wdata;

	assign ifu_bus.rdata   = io_master_rdata;
	assign ifu_bus.rresp   = io_master_rresp;
	assign ifu_bus.awready = 1'b0;
	assign ifu_bus.wready  = 1'b0;
	assign ifu_bus.bvalid  = 1'b0;
	assign ifu_bus.bresp   = 2'b00;

	assign lsu_bus.rdata = (state == XBAR_CLINT_RD) ? clint_bus.rdata : io_master_rdata;
	assign lsu_bus.rresp = (state == XBAR_CLINT_RD) ? clint_bus.rresp : io_master_rresp;
	assign lsu_bus.bresp = io_master_bresp;

	// timer is read only
	assign clint_bus.araddr  = lsu_bus.araddr;
	assign clint_bus.awaddr  = '0;
	assign clint_bus.awvalid = 1'b0;
	assign clint_bus.wdata   = '0;
	assign clint_bus.wvalid  = 1'b0;
	assign clint_bus.bready  = 1'b0;
endmodule

//--- test/core_assert.sv
module core_assert (
	input logic        clock,
	input logic        arst_n,
	input logic        io_master_awvalid,
	input logic        io_master_awready,
	input logic [31:0] io_master_awaddr,
	input logic        io_master_wvalid,
	input logic        io_master_wready,
	input logic [31:0] io_master_wdata,
	input logic        io_master_bready,
	input logic        io_master_arvalid,
	input logic        io_master_arready,
	input logic [31:0] io_master_araddr,
	input logic        io_master_rvalid,
	input logic        io_master_rready
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	logic w_fire;
	logic rd_pending;

	// awaddr stays on the bus while the data beat goes
	assign w_fire = io_master_wvalid && io_master_wready;

	// an external read is open from its ar beat to its r beat
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rd_pending <= 1'b0;
		end else if (io_master_arvalid && io_master_arready) begin
			rd_pending <= 1'b1;
		end else if (io_master_rvalid && io_master_rready) begin
			rd_pending <= 1'b0;
		end
	end

	// ============================================================
	// store values
	// ============================================================
	assert property (@(posedge clock) disable iff (!arst_n)
		w_fire && io_master_awaddr == 32'h100 |-> io_master_wdata == 32'd12)
		else begin
			$error("store to 0x100 carries a wrong sum");
			fail_count++;
		end

	assert property (@(posedge clock) disable iff (!arst_n)
		w_fire && io_master_awaddr == 32'h104 |-> io_master_wdata == 32'd2)
		else begin
			$error("store to 0x104 carries a wrong difference");
			fail_count++;
		end

	assert property (@(posedge clock) disable iff (!arst_n)
		w_fire && io_master_awaddr == 32'h108 |-> $signed(io_master_wdata) > 0)
		else begin
			$error("mtime did not advance between the two timer loads");
			fail_count++;
		end

	assert property (@(posedge clock) disable iff (!arst_n)
		!(io_master_awvalid && io_master_awaddr == 32'h10C))
		else begin
			$error("store to 0x10c issued although the branch was taken");
			fail_count++;
		end

	assert property (@(posedge clock) disable iff (!arst_n)
		w_fire && io_master_awaddr == 32'h110 |-> io_master_wdata == 32'd12)
		else begin
			$error("value loaded back from 0x100 is wrong");
			fail_count++;
		end

	// ============================================================
	// protocol
	// ============================================================
	assert property (@(posedge clock) disable iff (!arst_n)
		io_master_arvalid && !io_master_arready |=>
			io_master_arvalid && $stable(io_master_araddr))
		else begin
			$error("read address dropped or changed before arready");
			fail_count++;
		end

	assert property (@(posedge clock) disable iff (!arst_n)
		io_master_awvalid && !io_master_awready |=>
			io_master_awvalid && $stable(io_master_awaddr))
		else begin
			$error("write address dropped or changed before awready");
			fail_count++;
		end

	assert property (@(posedge clock) disable iff (!arst_n)
		io_master_wvalid && !io_master_wready |=>
			io_master_wvalid && $stable(io_master_wdata))
		else begin
			$error("write data dropped or changed before wready");
			fail_count++;
		end

	assert property (@(posedge clock) disable iff (!arst_n)
		io_master_rready |-> rd_pending)
		else begin
			$error("rready high while no read address was accepted");
			fail_count++;
		end

	assert property (@(posedge clock)
		!arst_n |-> !io_master_arvalid && !io_master_awvalid && !io_master_wvalid
			&& !io_master_bready && !io_master_rready)
		else begin
			$error("valid high while in reset");
			fail_count++;
		end
endmodule

bind core_top core_assert u_assert (
	.clock(clock),
	.arst_n(arst_n),
	.io_master_awvalid(io_master_awvalid),
	.io_master_awready(io_master_awready),
	.io_master_awaddr(io_master_awaddr),
	.io_master_wvalid(io_master_wvalid),
	.io_master_wready(io_master_wready),
	.io_master_wdata(io_master_wdata),
	.io_master_bready(io_master_bready),
	.io_master_arvalid(io_master_arvalid),
	.io_master_arready(io_master_arready),
	.io_master_araddr(io_master_araddr),
	.io_master_rvalid(io_master_rvalid),
	.io_master_rready(io_master_rready)
);

//--- test/core_tb.sv
module core_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned SEED            = 32'habee1705;
	// 15 retired instructions, up to about 33 cycles each with all delays at 3, times 4
	localparam int          PROG_INSTS      = 15;
	localparam int          MAX_INST_CYCLES = 33;
	localparam int          WATCHDOG_CYCLES = PROG_INSTS * MAX_INST_CYCLES * 4;
	localparam int          SPIN_CYCLES     = 60;

	logic        clock;
	logic        arst_n;
	logic        io_master_awready;
	logic        io_master_awvalid;
	logic [31:0] io_master_awaddr;
	logic        io_master_wready;
	logic        io_master_wvalid;
	logic [31:0] io_master_wdata;
	logic        io_master_bready;
	logic        io_master_bvalid;
	logic [1:0]  io_master_bresp;
	logic        io_master_arready;
	logic        io_master_arvalid;
	logic [31:0] io_master_araddr;
	logic        io_master_rready;
	logic        io_master_rvalid;
	logic [1:0]  io_master_rresp;
	logic [31:0] io_master_rdata;

	logic [31:0] mem [256];
	logic [4:0]  seen;
	int          passed;
	int          failed;

	core_top DUT (.*);

	always #10 clock = ~clock;

	// ============================================================
	// helpers
	// ============================================================
	task automatic wait_random;
		int n;
		n = $urandom_range(3, 0);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic report_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected == actual) begin
			$display("PASS %s", name);
			passed++;
		end else begin
			$display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
			failed++;
		end
	endtask

	task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
		case (addr)
			32'h100: begin
				seen[0] = 1'b1;
				report_value("arith_add", 32'd12, data);
			end
			32'h104: begin
				seen[1] = 1'b1;
				report_value("arith_sub", 32'd2, data);
			end
			32'h108: begin
				seen[2] = 1'b1;
				if ($signed(data) > 0) begin
					$display("PASS timer_read");
					passed++;
				end else begin
					$display("FAIL timer_read expected >0 actual 0x%08h", data);
					failed++;
				end
			end
			32'h10C: begin
				seen[4] = 1'b1;
				$display("FAIL branch_skip: a store to 0x10c happened although beq was taken");
				failed++;
			end
			32'h110: begin
				seen[3] = 1'b1;
				report_value("load_path", 32'd12, data);
			end
			default: begin
				$display("store to unexpected address 0x%08h with data 0x%08h", addr, data);
				failed++;
			end
		endcase
	endtask

	task automatic report_missing;
		if (!seen[0])
			$display("the store to 0x100 for arith_add never arrived");
		if (!seen[1])
			$display("the store to 0x104 for arith_sub never arrived");
		if (!seen[2])
			$display("the store to 0x108 for timer_read never arrived");
		if (!seen[3])
			$display("the store to 0x110 for load_path never arrived");
	endtask

	// ============================================================
	// memory model, read side
	// ============================================================
	initial begin
		logic [31:0] addr;
		forever begin
			@(posedge clock);
			#1;
			if (arst_n && io_master_arvalid) begin
				addr = io_master_araddr;
				wait_random();
				io_master_arready = 1'b1;
				@(posedge clock);
				#1;
				io_master_arready = 1'b0;
				wait_random();
				io_master_rdata  = mem[addr[9:2]];
				io_master_rvalid = 1'b1;
				while (!io_master_rready) begin
					@(posedge clock);
					#1;
				end
				@(posedge clock);
				#1;
				io_master_rvalid = 1'b0;
			end
		end
	end

	// ============================================================
	// memory model, write side
	// ============================================================
	initial begin
		logic [31:0] addr;
		logic [31:0] data;
		forever begin
			@(posedge clock);
			#1;
			if (arst_n && io_master_awvalid) begin
				addr = io_master_awaddr;
				data = io_master_wdata;
				wait_random();
				io_master_awready = 1'b1;
				@(posedge clock);
				#1;
				io_master_awready = 1'b0;
				wait_random();
				io_master_wready = 1'b1;
				while (!io_master_wvalid) begin
					@(posedge clock);
					#1;
				end
				@(posedge clock);
				#1;
				io_master_wready = 1'b0;
				mem[addr[9:2]] = data;
				wait_random();
				io_master_bvalid = 1'b1;
				while (!io_master_bready) begin
					@(posedge clock);
					#1;
				end
				@(posedge clock);
				#1;
				io_master_bvalid = 1'b0;
				check_store(addr, data);
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("timeout after %0d cycles", WATCHDOG_CYCLES);
		report_missing();
		$display("Simulation failed");
		$finish;
	end

	// ============================================================
	// program, reset and report
	// ============================================================
	initial begin
		int total_fail;
		void'($urandom(SEED));
		clock             = 1'b0;
		arst_n            = 1'b0;
		io_master_awready = 1'b0;
		io_master_wready  = 1'b0;
		io_master_bvalid  = 1'b0;
		io_master_bresp   = 2'b00;
		io_master_arready = 1'b0;
		io_master_rvalid  = 1'b0;
		io_master_rresp   = 2'b00;
		io_master_rdata   = '0;
		seen              = '0;
		passed            = 0;
		failed            = 0;
		for (int i = 0; i < 256; i++)
			mem[i] = 32'hf00d_0000 ^ (i * 32'h0001_0004);
		mem[0]  = 32'h00500093; // addi x1, x0, 5
		mem[1]  = 32'h00700113; // addi x2, x0, 7
		mem[2]  = 32'h002081b3; // add  x3, x1, x2
		mem[3]  = 32'h40110233; // sub  x4, x2, x1
		mem[4]  = 32'h10302023; // sw   x3, 0x100(x0)
		mem[5]  = 32'h10402223; // sw   x4, 0x104(x0)
		mem[6]  = 32'h020002b7; // lui  x5, 0x02000
		mem[7]  = 32'h0002a303; // lw   x6, 0(x5)
		mem[8]  = 32'h0002a383; // lw   x7, 0(x5)
		mem[9]  = 32'h40638433; // sub  x8, x7, x6
		mem[10] = 32'h10802423; // sw   x8, 0x108(x0)
		mem[11] = 32'h00000463; // beq  x0, x0, +8
		mem[12] = 32'h10302623; // sw   x3, 0x10c(x0)
		mem[13] = 32'h10002503; // lw   x10, 0x100(x0)
		mem[14] = 32'h10a02823; // sw   x10, 0x110(x0)
		mem[15] = 32'h0000006f; // jal  x0, 0

		repeat (5) @(posedge clock);
		#1;
		arst_n = 1'b1;

		wait (seen[3:0] == 4'hf);
		// let the final jal spin a while, a stray store would show up here
		repeat (SPIN_CYCLES) @(posedge clock);
		if (!seen[4]) begin
			$display("PASS branch_skip");
			passed++;
		end

		total_fail = failed + DUT.u_assert.fail_count;
		$display("tests: %0d passed, %0d failed, %0d assertion failures",
			passed, failed, DUT.u_assert.fail_count);
		if (total_fail == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end
endmodule
